/* src/seg_pkg.sv */
// widths, field types, beat structs and tkeep to mty conversion for the segment converter
package seg_pkg;

    // *******************************************************************
    // widths
    // *******************************************************************
    localparam int SEG_DW      = 32;                   // one egress segment
    localparam int SEGS_PER_CH = 2;                    // tid/tdest packing assumes 2
    localparam int ING_DW      = SEGS_PER_CH * SEG_DW; // ingress beat
    localparam int SEG_KW      = SEG_DW / 8;           // keep bits per segment
    localparam int MTY_W       = $clog2(SEG_KW);       // empty byte count
    localparam int XFER_ID_W   = 2;
    localparam int SEG_TID_W   = 3;

    typedef logic [ING_DW-1:0]       ing_data_t;
    typedef logic [ING_DW/8-1:0]     ing_keep_t;
    typedef logic [5:0]              ing_tid_t;        // {xfer_id, sop[1:0], eop[1:0]}
    typedef logic [6:0]              ing_tdest_t;      // {alt_id, seg_tid, err[1:0]}
    typedef logic [SEG_DW-1:0]       seg_data_t;
    typedef logic [XFER_ID_W-1:0]    xfer_id_t;
    typedef logic [SEG_TID_W-1:0]    seg_tid_t;
    typedef logic [MTY_W-1:0]        seg_mty_t;

    // *******************************************************************
    // beat structs
    // *******************************************************************
    typedef struct packed {
        ing_data_t  data;
        ing_keep_t  keep;
        ing_tid_t   tid;
        ing_tdest_t tdest;
    } ing_beat_t;

    // egress FIFO entry, keep already converted
    typedef struct packed {
        ing_data_t                   data;
        seg_mty_t [SEGS_PER_CH-1:0]  mty;
        logic [SEGS_PER_CH-1:0]      ena;
        ing_tid_t                    tid;
        ing_tdest_t                  tdest;
    } conv_beat_t;

    typedef struct packed {
        seg_data_t data;
        logic      ena;
        logic      sop;
        logic      eop;
        logic      err;
        seg_mty_t  mty;
    } seg_beat_t;

    typedef seg_beat_t [SEGS_PER_CH-1:0] ch_seg_t;

    // empty bytes above the highest kept byte, all-zero keep gives 0
    function automatic seg_mty_t keep_to_mty(input logic [SEG_KW-1:0] keep);
        seg_mty_t mty;
        mty = '0;
        for (int i = 0; i < SEG_KW; i++) begin
            if (keep[i]) mty = seg_mty_t'(SEG_KW - 1 - i); // highest set bit wins
        end
        return mty;
    endfunction

endpackage

/* src/seg_fifo.sv */
// seg_fifo: synchronous first-word-fall-through FIFO with fill count and almost-full flag
module seg_fifo #(
    parameter int WIDTH    = 8,
    parameter int DEPTH    = 16,
    parameter int AF_LEVEL = DEPTH - 4
) (
    input  logic                       aclk,
    input  logic                       local_rstn,
    input  logic                       wr_en,
    input  logic [WIDTH-1:0]           wr_data,
    output logic                       full,
    input  logic                       rd_en,
    output logic [WIDTH-1:0]           rd_data,
    output logic                       rd_valid,
    output logic [$clog2(DEPTH+1)-1:0] fill,
    output logic                       almost_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr    = wr_en & ~full;
    assign do_rd    = rd_en & rd_valid;
    assign full     = (count == CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = rd_valid ? mem[rd_ptr] : '0; // head reads zero while empty
    assign fill     = count;

    always_ff @(posedge aclk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    // *******************************************************************
    // pointers and occupancy
    // *******************************************************************
    always_ff @(posedge aclk) begin
        if (!local_rstn) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or simultaneous
            endcase
            almost_full <= (count >= CNT_W'(AF_LEVEL)); // one cycle behind fill
        end
    end

endmodule

/* src/seg_channel.sv */
// seg_channel: ingress FIFO, keep conversion stage, egress FIFO and segment field unpacking
module seg_channel #(
    parameter int ING_DEPTH = 16,
    parameter int EGR_DEPTH = 16,
    parameter int MIN_FILL  = 4
) (
    input  logic                aclk,
    input  logic                local_rstn,
    input  logic                ing_valid,
    output logic                ing_ready,
    input  seg_pkg::ing_beat_t  ing_beat,
    input  logic                pop,
    output logic                ing_head_valid,
    output logic                ing_level_ok,
    output logic                egr_almost_full,
    output logic                seg_valid,
    input  logic                seg_ready,
    output seg_pkg::ch_seg_t    seg_out,
    output seg_pkg::xfer_id_t   head_xfer_id,
    output seg_pkg::xfer_id_t   head_alt_id,
    output seg_pkg::seg_tid_t   head_seg_tid
);

    localparam int ING_FILL_W = $clog2(ING_DEPTH + 1);
    localparam int EGR_AF     = EGR_DEPTH - 4;   // room for beats still in flight

    logic                    ing_full;
    seg_pkg::ing_beat_t      ing_head;
    logic [ING_FILL_W-1:0]   ing_fill;
    seg_pkg::conv_beat_t     conv_next;
    seg_pkg::conv_beat_t     conv_beat;
    logic                    conv_vld;
    seg_pkg::conv_beat_t     egr_head;

    logic [seg_pkg::SEGS_PER_CH-1:0] egr_sop;
    logic [seg_pkg::SEGS_PER_CH-1:0] egr_eop;
    logic [seg_pkg::SEGS_PER_CH-1:0] egr_err;

    // *******************************************************************
    // ingress buffer
    // *******************************************************************
    assign ing_ready = ~ing_full;

    seg_fifo #(
        .WIDTH    ($bits(seg_pkg::ing_beat_t)),
        .DEPTH    (ING_DEPTH),
        .AF_LEVEL (ING_DEPTH)
    ) ing_fifo (
        .aclk        (aclk),
        .local_rstn  (local_rstn),
        .wr_en       (ing_valid & ing_ready),
        .wr_data     (ing_beat),
        .full        (ing_full),
        .rd_en       (pop),
        .rd_data     (ing_head),
        .rd_valid    (ing_head_valid),
        .fill        (ing_fill),
        .almost_full ()
    );

    always_ff @(posedge aclk) begin
        if (!local_rstn) begin
            ing_level_ok <= 1'b0;
        end else begin
            ing_level_ok <= (ing_fill >= ING_FILL_W'(MIN_FILL));
        end
    end

    // *******************************************************************
    // keep conversion stage
    // *******************************************************************
    always_comb begin
        conv_next.data  = ing_head.data;
        conv_next.tid   = ing_head.tid;
        conv_next.tdest = ing_head.tdest;
        for (int seg = 0; seg < seg_pkg::SEGS_PER_CH; seg++) begin
            conv_next.mty[seg] = seg_pkg::keep_to_mty(
                ing_head.keep[seg*seg_pkg::SEG_KW +: seg_pkg::SEG_KW]);
            conv_next.ena[seg] = ing_head.keep[seg*seg_pkg::SEG_KW]; // lowest byte of segment
        end
    end

    always_ff @(posedge aclk) begin
        conv_beat <= conv_next;
    end

    always_ff @(posedge aclk) begin
        if (!local_rstn) begin
            conv_vld <= 1'b0;
        end else begin
            conv_vld <= pop;
        end
    end

    seg_fifo #(
        .WIDTH    ($bits(seg_pkg::conv_beat_t)),
        .DEPTH    (EGR_DEPTH),
        .AF_LEVEL (EGR_AF)
    ) egr_fifo (
        .aclk        (aclk),
        .local_rstn  (local_rstn),
        .wr_en       (conv_vld),
        .wr_data     (conv_beat),
        .full        (),
        .rd_en       (seg_ready),
        .rd_data     (egr_head),
        .rd_valid    (seg_valid),
        .fill        (),
        .almost_full (egr_almost_full)
    );

    // *******************************************************************
    // egress unpacking
    // *******************************************************************
    assign {head_xfer_id, egr_sop, egr_eop}     = egr_head.tid;   // matches source packing
    assign {head_alt_id, head_seg_tid, egr_err} = egr_head.tdest;

    always_comb begin
        for (int seg = 0; seg < seg_pkg::SEGS_PER_CH; seg++) begin
            seg_out[seg].data = egr_head.data[seg*seg_pkg::SEG_DW +: seg_pkg::SEG_DW];
            seg_out[seg].ena  = egr_head.ena[seg] & seg_valid;  // no ena without valid
            seg_out[seg].sop  = egr_sop[seg];
            seg_out[seg].eop  = egr_eop[seg];
            seg_out[seg].err  = egr_err[seg];
            seg_out[seg].mty  = egr_head.mty[seg];
        end
    end

endmodule

/* src/drain_ctrl.sv */
// drain_ctrl: start gate on minimum ingress fill, combined egress room and lock-step pop
module drain_ctrl #(
    parameter int NUM_CH   = 2,
    parameter int MIN_FILL = 4
) (
    input  logic              aclk,
    input  logic              local_rstn,
    input  logic [NUM_CH-1:0] head_valid,
    input  logic [NUM_CH-1:0] level_ok,
    input  logic [NUM_CH-1:0] almost_full,
    output logic              pop
);

    logic start_ok;
    logic align_rdy;   // first gate stage
    logic drain_en;    // second gate stage
    logic egr_room;

    // with no fill requirement any beat on every channel is enough
    assign start_ok = (MIN_FILL == 0) ? (&head_valid) : (&level_ok);

    // *******************************************************************
    // start gate
    // *******************************************************************
    always_ff @(posedge aclk) begin
        if (!local_rstn || head_valid == '0) begin
            align_rdy <= 1'b0;
            drain_en  <= 1'b0;
        end else begin
            if (start_ok) align_rdy <= 1'b1; // sticky until all drained
            drain_en <= align_rdy;
        end
    end

    // room only when no egress FIFO is near full
    always_ff @(posedge aclk) begin
        if (!local_rstn) begin
            egr_room <= 1'b0;
        end else begin
            egr_room <= ~(|almost_full);
        end
    end

    // every channel pops the same beat index in the same cycle
    assign pop = drain_en & (&head_valid) & egr_room;

endmodule

/* src/align_checker.sv */
// align_checker: two-stage registered comparison of transfer ids and segment tids
module align_checker #(
    parameter int NUM_CH = 2
) (
    input  logic              aclk,
    input  logic              local_rstn,
    input  seg_pkg::xfer_id_t xfer_id [NUM_CH],
    input  seg_pkg::xfer_id_t alt_id  [NUM_CH],
    input  seg_pkg::seg_tid_t seg_tid [NUM_CH],
    output logic              err_alignment
);

    logic [NUM_CH-2:0] id_ne;     // neighbour transfer id mismatch
    logic [NUM_CH-2:0] tid_ne;    // neighbour segment tid mismatch
    logic              alt_ne;
    logic              alt_any;

    always_comb begin
        alt_any = 1'b0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            alt_any = alt_any | (xfer_id[ch] != alt_id[ch]);
        end
    end

    // *******************************************************************
    // stage one compares, stage two combines
    // *******************************************************************
    always_ff @(posedge aclk) begin
        if (!local_rstn) begin
            id_ne         <= '0;
            tid_ne        <= '0;
            alt_ne        <= 1'b0;
            err_alignment <= 1'b0;
        end else begin
            for (int ch = 0; ch < NUM_CH - 1; ch++) begin
                id_ne[ch]  <= (xfer_id[ch] != xfer_id[ch+1]);
                tid_ne[ch] <= (seg_tid[ch] != seg_tid[ch+1]);
            end
            alt_ne        <= alt_any;
            err_alignment <= (|id_ne) | (|tid_ne) | alt_ne;
        end
    end

endmodule

/* src/axis_to_seg_top.sv */
// axis_to_seg_top: channel generate loop, drain controller and alignment checker
module axis_to_seg_top #(
    parameter int NUM_CH    = 2,
    parameter int ING_DEPTH = 16,
    parameter int EGR_DEPTH = 16
) (
    input  logic               aclk,
    input  logic               local_rstn,
    input  logic [NUM_CH-1:0]  ing_valid,
    output logic [NUM_CH-1:0]  ing_ready,
    input  seg_pkg::ing_beat_t ing_beat [NUM_CH],
    output logic [NUM_CH-1:0]  seg_valid,
    input  logic [NUM_CH-1:0]  seg_ready,
    output seg_pkg::ch_seg_t   seg_out  [NUM_CH],
    output seg_pkg::seg_tid_t  seg_tid,
    output logic               err_alignment
);

    localparam int MIN_FILL = ING_DEPTH / 4;

    logic [NUM_CH-1:0] head_valid;
    logic [NUM_CH-1:0] level_ok;
    logic [NUM_CH-1:0] almost_full;
    logic              pop;          // shared by all channels

    seg_pkg::xfer_id_t head_xfer_id [NUM_CH];
    seg_pkg::xfer_id_t head_alt_id  [NUM_CH];
    seg_pkg::seg_tid_t head_seg_tid [NUM_CH];

    // *******************************************************************
    // channels
    // *******************************************************************
    for (genvar ch = 0; ch < NUM_CH; ch++) begin : gen_ch
        seg_channel #(
            .ING_DEPTH (ING_DEPTH),
            .EGR_DEPTH (EGR_DEPTH),
            .MIN_FILL  (MIN_FILL)
        ) u_channel (
            .aclk            (aclk),
            .local_rstn      (local_rstn),
            .ing_valid       (ing_valid[ch]),
            .ing_ready       (ing_ready[ch]),
            .ing_beat        (ing_beat[ch]),
            .pop             (pop),
            .ing_head_valid  (head_valid[ch]),
            .ing_level_ok    (level_ok[ch]),
            .egr_almost_full (almost_full[ch]),
            .seg_valid       (seg_valid[ch]),
            .seg_ready       (seg_ready[ch]),
            .seg_out         (seg_out[ch]),
            .head_xfer_id    (head_xfer_id[ch]),
            .head_alt_id     (head_alt_id[ch]),
            .head_seg_tid    (head_seg_tid[ch])
        );
    end

    drain_ctrl #(
        .NUM_CH   (NUM_CH),
        .MIN_FILL (MIN_FILL)
    ) u_drain (
        .aclk        (aclk),
        .local_rstn  (local_rstn),
        .head_valid  (head_valid),
        .level_ok    (level_ok),
        .almost_full (almost_full),
        .pop         (pop)
    );

    align_checker #(
        .NUM_CH (NUM_CH)
    ) u_align (
        .aclk          (aclk),
        .local_rstn    (local_rstn),
        .xfer_id       (head_xfer_id),
        .alt_id        (head_alt_id),
        .seg_tid       (head_seg_tid),
        .err_alignment (err_alignment)
    );

    assign seg_tid = head_seg_tid[0];  // channel 0 speaks for all

endmodule

/* test/axis_to_seg_props.sv */
// concurrent assertions on egress lock-step, ena gating, reset values and ingress ready
module axis_to_seg_props #(
    parameter int NUM_CH    = 2,
    parameter int ING_DEPTH = 16
) (
    input logic              aclk,
    input logic              local_rstn,
    input logic [NUM_CH-1:0] ing_valid,
    input logic [NUM_CH-1:0] ing_ready,
    input logic              pop,
    input logic [NUM_CH-1:0] seg_valid,
    input logic [NUM_CH-1:0] seg_ready,
    input seg_pkg::ch_seg_t  seg_out [NUM_CH],
    input logic              err_alignment
);
    timeunit 1ns;
    timeprecision 100ps;

    logic after_rst;          // previous edge saw reset
    int   stored [NUM_CH];    // beats held in each ingress FIFO

    always_ff @(posedge aclk) begin
        after_rst <= ~local_rstn;
    end

    always_ff @(posedge aclk) begin
        for (int c = 0; c < NUM_CH; c++) begin
            if (!local_rstn) begin
                stored[c] <= 0;
            end else begin
                stored[c] <= stored[c] + int'(ing_valid[c] & ing_ready[c]) - int'(pop);
            end
        end
    end

    a_valid_lockstep: assert property (@(posedge aclk) disable iff (!local_rstn)
        (seg_ready == '1) |-> (seg_valid == '0 || seg_valid == '1))
        else $error("seg_valid differs across channels while every seg_ready is high");

    a_reset_quiet: assert property (@(posedge aclk)
        after_rst |-> (seg_valid == '0 && !err_alignment))
        else $error("seg_valid or err_alignment set in the cycle after reset");

    for (genvar c = 0; c < NUM_CH; c++) begin : gen_ch
        a_ready_room: assert property (@(posedge aclk) disable iff (!local_rstn)
            (stored[c] < ING_DEPTH) |-> ing_ready[c])
            else $error("ing_ready low on channel %0d with ingress room left", c);
        for (genvar g = 0; g < seg_pkg::SEGS_PER_CH; g++) begin : gen_seg
            a_ena_valid: assert property (@(posedge aclk) disable iff (!local_rstn)
                !seg_valid[c] |-> !seg_out[c][g].ena)
                else $error("ena set on channel %0d segment %0d without seg_valid", c, g);
        end
    end

endmodule

bind axis_to_seg_top axis_to_seg_props #(
    .NUM_CH    (NUM_CH),
    .ING_DEPTH (ING_DEPTH)
) u_props (
    .aclk          (aclk),
    .local_rstn    (local_rstn),
    .ing_valid     (ing_valid),
    .ing_ready     (ing_ready),
    .pop           (pop),
    .seg_valid     (seg_valid),
    .seg_ready     (seg_ready),
    .seg_out       (seg_out),
    .err_alignment (err_alignment)
);

/* test/axis_to_seg_tb.sv */
// testbench: clock, reset, stimulus table, scoreboard, checks and timeout
module axis_to_seg_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CH      = 2;
    localparam int ING_DEPTH   = 16;
    localparam int EGR_DEPTH   = 16;
    localparam int NUM_ROWS    = 9;
    localparam int CYCLE_LIMIT = 40 * NUM_ROWS + 200;

    typedef struct packed {
        seg_pkg::ing_keep_t [NUM_CH-1:0] keep;
        logic [1:0]                      sop;
        logic [1:0]                      eop;
        logic [1:0]                      err;
        seg_pkg::xfer_id_t [NUM_CH-1:0]  xid;
        seg_pkg::xfer_id_t [NUM_CH-1:0]  alt;
        seg_pkg::seg_tid_t [NUM_CH-1:0]  stid;
        logic                            exp_err;
    } row_t;

    typedef struct packed {
        seg_pkg::ing_data_t [NUM_CH-1:0] data;
        int                              row;
    } sent_t;

    logic               aclk;
    logic               local_rstn;
    logic [NUM_CH-1:0]  ing_valid;
    logic [NUM_CH-1:0]  ing_ready;
    seg_pkg::ing_beat_t ing_beat [NUM_CH];
    logic [NUM_CH-1:0]  seg_valid;
    logic [NUM_CH-1:0]  seg_ready;
    seg_pkg::ch_seg_t   seg_out  [NUM_CH];
    seg_pkg::seg_tid_t  seg_tid;
    logic               err_alignment;

    row_t   table_rows [NUM_ROWS];
    string  row_names  [NUM_ROWS];
    sent_t  sent_q [$];                 // beats accepted, oldest first
    integer seed = 32'h943a_bf14;
    int     err_count = 0;
    int     check_count = 0;
    int     cycles = 0;
    logic   saw_stall;

    axis_to_seg_top #(
        .NUM_CH    (NUM_CH),
        .ING_DEPTH (ING_DEPTH),
        .EGR_DEPTH (EGR_DEPTH)
    ) u_axis_to_seg_top (
        .aclk          (aclk),
        .local_rstn    (local_rstn),
        .ing_valid     (ing_valid),
        .ing_ready     (ing_ready),
        .ing_beat      (ing_beat),
        .seg_valid     (seg_valid),
        .seg_ready     (seg_ready),
        .seg_out       (seg_out),
        .seg_tid       (seg_tid),
        .err_alignment (err_alignment)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // *******************************************************************
    // helpers
    // *******************************************************************
    // bytes above the top kept byte, zero keep counts as none
    function automatic logic [1:0] empty_bytes(input logic [3:0] keep);
        int n;
        n = 0;
        if (keep != 4'b0000) begin
            while (n < 3 && keep[3 - n] == 1'b0) begin
                n++;
            end
        end
        return 2'(n);
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
        check_count++;
        if (exp_val !== act_val) begin
            err_count++;
            $display("FAILED %s expected %0h actual %0h", name, exp_val, act_val);
        end
    endtask

    task automatic add_row(input int idx, input string name, input logic [NUM_CH*8-1:0] keep,
                           input logic [1:0] sop, input logic [1:0] eop, input logic [1:0] err,
                           input logic [NUM_CH*2-1:0] xid, input logic [NUM_CH*2-1:0] alt,
                           input logic [NUM_CH*3-1:0] stid, input logic exp_err);
        row_names[idx]          = name;
        table_rows[idx].keep    = keep;
        table_rows[idx].sop     = sop;
        table_rows[idx].eop     = eop;
        table_rows[idx].err     = err;
        table_rows[idx].xid     = xid;
        table_rows[idx].alt     = alt;
        table_rows[idx].stid    = stid;
        table_rows[idx].exp_err = exp_err;
    endtask

    task automatic next_drive_slot();
        @(posedge aclk);
        #2;
    endtask

    // present one row on every channel and hold it until all channels take it
    task automatic send_row(input int r);
        sent_t s;
        s.row = r;
        for (int c = 0; c < NUM_CH; c++) begin
            s.data[c]         = {32'($random(seed)), 32'($random(seed))};
            ing_beat[c].data  = s.data[c];
            ing_beat[c].keep  = table_rows[r].keep[c];
            ing_beat[c].tid   = {table_rows[r].xid[c], table_rows[r].sop, table_rows[r].eop};
            ing_beat[c].tdest = {table_rows[r].alt[c], table_rows[r].stid[c], table_rows[r].err};
        end
        ing_valid = '1;
        @(negedge aclk);
        while (ing_ready != '1) begin
            @(negedge aclk);
        end
        next_drive_slot();
        ing_valid = '0;
        sent_q.push_back(s);
    endtask

    task automatic drain_wait();
        while (sent_q.size() != 0) begin
            @(posedge aclk);
        end
        #2;
    endtask

    task automatic check_egress(input sent_t s);
        row_t  r;
        string pre;
        r = table_rows[s.row];
        for (int c = 0; c < NUM_CH; c++) begin
            for (int g = 0; g < seg_pkg::SEGS_PER_CH; g++) begin
                pre = $sformatf("%s ch%0d seg%0d", row_names[s.row], c, g);
                check_val({pre, " data"}, 64'(s.data[c][g*seg_pkg::SEG_DW +: seg_pkg::SEG_DW]),
                          64'(seg_out[c][g].data));
                check_val({pre, " mty"}, 64'(empty_bytes(r.keep[c][g*4 +: 4])),
                          64'(seg_out[c][g].mty));
                check_val({pre, " ena"}, 64'(r.keep[c][g*4]), 64'(seg_out[c][g].ena));
                check_val({pre, " sop"}, 64'(r.sop[g]), 64'(seg_out[c][g].sop));
                check_val({pre, " eop"}, 64'(r.eop[g]), 64'(seg_out[c][g].eop));
                check_val({pre, " err"}, 64'(r.err[g]), 64'(seg_out[c][g].err));
            end
        end
        check_val({row_names[s.row], " seg_tid"}, 64'(r.stid[0]), 64'(seg_tid));
    endtask

    // *******************************************************************
    // egress scoreboard, sampled mid-cycle
    // *******************************************************************
    always @(negedge aclk) begin : egress_monitor
        sent_t s;
        if (local_rstn) begin
            for (int c = 0; c < NUM_CH; c++) begin
                for (int g = 0; g < seg_pkg::SEGS_PER_CH; g++) begin
                    if (!seg_valid[c]) begin
                        check_val("ena while invalid", 64'(0), 64'(seg_out[c][g].ena));
                    end
                end
            end
            if (seg_ready == '1 && seg_valid != '0) begin
                check_val("lockstep seg_valid", 64'({NUM_CH{1'b1}}), 64'(seg_valid));
                if (sent_q.size() == 0) begin
                    err_count++;
                    $display("an egress beat appeared while no beat was outstanding");
                end else begin
                    s = sent_q.pop_front();
                    check_egress(s);
                end
            end
        end
    end

    // *******************************************************************
    // test sequence
    // *******************************************************************
    initial begin
        local_rstn = 1'b0;
        ing_valid  = '0;
        seg_ready  = '1;
        saw_stall  = 1'b0;
        for (int c = 0; c < NUM_CH; c++) begin
            ing_beat[c] = '0;
        end
        // keep, sop, eop, err, xid, alt and stid columns list channel 1 first
        add_row(0, "full_keep", {8'hff, 8'hff}, 2'b01, 2'b00, 2'b00,
                {2'd1, 2'd1}, {2'd1, 2'd1}, {3'd2, 3'd2}, 1'b0);
        add_row(1, "top_empty", {8'h3f, 8'h7f}, 2'b00, 2'b00, 2'b00,
                {2'd1, 2'd1}, {2'd1, 2'd1}, {3'd2, 3'd2}, 1'b0);
        add_row(2, "short_tail", {8'h01, 8'h17}, 2'b00, 2'b10, 2'b00,
                {2'd1, 2'd1}, {2'd1, 2'd1}, {3'd2, 3'd2}, 1'b0);
        add_row(3, "gap_keep", {8'he5, 8'h5a}, 2'b11, 2'b01, 2'b00,
                {2'd3, 2'd3}, {2'd3, 2'd3}, {3'd5, 3'd5}, 1'b0);
        add_row(4, "seg_errors", {8'h0f, 8'hff}, 2'b01, 2'b01, 2'b11,
                {2'd0, 2'd0}, {2'd0, 2'd0}, {3'd7, 3'd7}, 1'b0);
        add_row(5, "low_seg_only", {8'h0f, 8'h0f}, 2'b10, 2'b10, 2'b01,
                {2'd2, 2'd2}, {2'd2, 2'd2}, {3'd1, 3'd1}, 1'b0);
        add_row(6, "xid_mismatch", {8'hff, 8'hff}, 2'b01, 2'b00, 2'b00,
                {2'd2, 2'd1}, {2'd2, 2'd1}, {3'd4, 3'd4}, 1'b1);
        add_row(7, "stid_mismatch", {8'hff, 8'hff}, 2'b01, 2'b00, 2'b00,
                {2'd3, 2'd3}, {2'd3, 2'd3}, {3'd6, 3'd4}, 1'b1);
        add_row(8, "alt_mismatch", {8'hff, 8'hff}, 2'b01, 2'b00, 2'b00,
                {2'd1, 2'd1}, {2'd3, 2'd1}, {3'd4, 3'd4}, 1'b1);

        repeat (4) @(posedge aclk);
        #2;
        local_rstn = 1'b1;
        @(negedge aclk);
        check_val("reset seg_valid", 64'(0), 64'(seg_valid));
        check_val("reset err_alignment", 64'(0), 64'(err_alignment));
        check_val("reset ing_ready", 64'({NUM_CH{1'b1}}), 64'(ing_ready));
        next_drive_slot();

        for (int r = 0; r < 3; r++) begin
            send_row(r);                       // below the minimum fill
        end
        repeat (20) begin
            @(negedge aclk);
            check_val("below min fill seg_valid", 64'(0), 64'(seg_valid));
        end
        next_drive_slot();
        for (int r = 3; r < 6; r++) begin
            send_row(r);
        end
        drain_wait();

        seg_ready = '0;
        fork
            begin
                for (int i = 0; i < 36; i++) begin
                    send_row(i % 6);
                end
            end
            begin
                repeat (60) begin
                    @(negedge aclk);
                    if (ing_ready != '1) begin
                        saw_stall = 1'b1;
                    end
                end
                next_drive_slot();
                seg_ready = '1;
            end
        join
        check_val("backpressure ing_ready drop", 64'(1), 64'(saw_stall));
        drain_wait();

        for (int e = 6; e < NUM_ROWS; e++) begin
            seg_ready = '0;
            send_row(e);
            for (int r = 0; r < 3; r++) begin
                send_row(r);                   // matching rows fill up to the gate
            end
            @(negedge aclk);
            while (seg_valid != '1) begin
                @(negedge aclk);
            end
            repeat (3) @(negedge aclk);
            check_val({row_names[e], " err_alignment"}, 64'(table_rows[e].exp_err),
                      64'(err_alignment));
            next_drive_slot();
            seg_ready = '1;                    // release only the bad head
            next_drive_slot();
            seg_ready = '0;
            repeat (3) @(negedge aclk);
            check_val({row_names[0], " err_alignment after"}, 64'(table_rows[0].exp_err),
                      64'(err_alignment));
            next_drive_slot();
            seg_ready = '1;
            drain_wait();
        end

        $display("checks %0d errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
src/seg_pkg.sv
src/seg_fifo.sv
src/seg_channel.sv
src/drain_ctrl.sv
src/align_checker.sv
src/axis_to_seg_top.sv
test/axis_to_seg_props.sv
test/axis_to_seg_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module axis_to_seg_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vaxis_to_seg_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
